// File: verilog/gemm_params.svh
`ifndef GEMM_PARAMS_SVH
`define GEMM_PARAMS_SVH

// lanes per bank, also activations per bank
`define GEMM_MAC_COUNT 32
`define GEMM_LANE_BITS 5
// activation banks in the 128 byte vector
`define GEMM_BANKS 4
`define GEMM_BANK_BITS 2
// activation and weight width
`define GEMM_DATA_WIDTH 8
`define GEMM_ACC_WIDTH 32
// command program, pc wraps at the end
`define GEMM_PROGRAM_DEPTH 512
`define GEMM_PC_WIDTH 9
// weight rows of 32 weights each
`define GEMM_WEIGHT_ROWS 384
`define GEMM_ROW_WIDTH 9
// relu divides by 2**shift then clamps
`define GEMM_RELU_SHIFT 7
`define GEMM_RELU_MAX 127
`define GEMM_PROGRESS_WIDTH 16

`endif

// File: verilog/gemm_pkg.sv
`include "gemm_params.svh"

package gemm_pkg;

    // one signed activation or weight
    typedef logic signed [`GEMM_DATA_WIDTH-1:0] act_t;

    // one lane accumulator, wraps on overflow
    typedef logic signed [`GEMM_ACC_WIDTH-1:0] acc_t;

    typedef logic [`GEMM_BANK_BITS-1:0] bank_t;

    // program word, msb first
    typedef struct packed {
        // first command of a group loads instead of adding
        logic clear;
        bank_t in_bank;
        // old bias index, ignored
        logic [2:0] reserved;
        bank_t out_bank;
    } command_t;

    // one row of weights, one per lane
    typedef act_t [`GEMM_MAC_COUNT-1:0] weight_row_t;

    // byte index is bank * 32 + lane
    typedef act_t [`GEMM_BANKS*`GEMM_MAC_COUNT-1:0] act_vector_t;

    typedef acc_t [`GEMM_MAC_COUNT-1:0] acc_vector_t;

endpackage

// File: verilog/gemm_issue_if.sv
`timescale 1ns/1ns

// operands of one issued command, decode to mac lanes
interface gemm_issue_if import gemm_pkg::*; ();

    // registered strobe, low on a bubble
    logic valid;

    // load product instead of adding
    logic clear;

    // shared activation picked from the input bank
    act_t activation;

    // per lane weights of this command
    weight_row_t weights;

    // bank the result goes to, also used by the hazard check
    bank_t out_bank;

    // decode side
    modport issue (
        output valid,
        output clear,
        output activation,
        output weights,
        output out_bank
    );

    // lanes only listen, no push back
    modport accept (
        input valid,
        input clear,
        input activation,
        input weights,
        input out_bank
    );

endinterface

// File: verilog/command_decode.sv
`timescale 1ns/1ns
`include "gemm_params.svh"

module command_decode import gemm_pkg::*; (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic restart_program,
    input act_vector_t activations_in,
    input logic program_write,
    input logic [`GEMM_PC_WIDTH-1:0] program_addr,
    input command_t program_data,
    input logic weight_write,
    input logic [`GEMM_ROW_WIDTH-1:0] weight_row,
    input weight_row_t weight_data,
    input logic result_valid,
    input bank_t result_bank,
    output logic [`GEMM_PROGRESS_WIDTH-1:0] progress,
    output command_t command,
    gemm_issue_if.issue issue_bus
);

    command_t program_mem [0:`GEMM_PROGRAM_DEPTH-1];
    weight_row_t weight_mem [0:`GEMM_WEIGHT_ROWS-1];

    logic [`GEMM_PC_WIDTH-1:0] pc;
    logic [`GEMM_ROW_WIDTH-1:0] row_count;
    logic bank_hazard;
    act_t selected_activation;

    // memory writes ignore enable
    always_ff @(posedge clk) begin
        if (program_write) begin
            program_mem[program_addr] <= program_data;
        end
    end

    // rows past the end are dropped
    always_ff @(posedge clk) begin
        if (weight_write && weight_row < `GEMM_WEIGHT_ROWS) begin
            weight_mem[weight_row] <= weight_data;
        end
    end

    assign command = program_mem[pc];
    assign progress = {{(`GEMM_PROGRESS_WIDTH-`GEMM_PC_WIDTH){1'b0}}, pc};

    // input bank still being produced
    // in the issue regs or one stage later in the lanes
    assign bank_hazard =
        (issue_bus.valid && command.in_bank == issue_bus.out_bank) ||
        (result_valid && command.in_bank == result_bank);

    // byte in_bank * 32 + pc mod 32
    assign selected_activation = activations_in[{command.in_bank, pc[`GEMM_LANE_BITS-1:0]}];

    // pc, weight row and issue strobe
    always_ff @(posedge clk) begin
        if (reset || restart_program) begin
            pc <= '0;
            row_count <= '0;
            issue_bus.valid <= 1'b0;
        end else if (enable) begin
            // stall sends a bubble and keeps pc
            issue_bus.valid <= !bank_hazard;
            if (!bank_hazard) begin
                pc <= pc + 1'b1;
                // sticks on the last row
                if (row_count != `GEMM_WEIGHT_ROWS - 1) begin
                    row_count <= row_count + 1'b1;
                end
            end
        end
    end

    // operands, qualified by valid
    always_ff @(posedge clk) begin
        if (enable && !bank_hazard) begin
            issue_bus.activation <= selected_activation;
            issue_bus.weights <= weight_mem[row_count];
            issue_bus.clear <= command.clear;
            issue_bus.out_bank <= command.out_bank;
        end
    end

endmodule

// File: verilog/mac_array.sv
`timescale 1ns/1ns
`include "gemm_params.svh"

module mac_array import gemm_pkg::*; (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic restart_program,
    gemm_issue_if.accept issue_bus,
    output acc_vector_t accumulators,
    output logic result_valid,
    output bank_t result_bank
);

    acc_vector_t products;

    // shared activation times each lane weight
    // signed 8x8, extended to 32 by the assignment
    always_comb begin
        for (int lane = 0; lane < `GEMM_MAC_COUNT; lane++) begin
            products[lane] = $signed(issue_bus.activation) * $signed(issue_bus.weights[lane]);
        end
    end

    // lanes update one cycle after issue
    always_ff @(posedge clk) begin
        if (reset || restart_program) begin
            accumulators <= '0;
            result_valid <= 1'b0;
        end else if (enable) begin
            result_valid <= issue_bus.valid;
            if (issue_bus.valid) begin
                for (int lane = 0; lane < `GEMM_MAC_COUNT; lane++) begin
                    // clear starts a new group
                    if (issue_bus.clear) begin
                        accumulators[lane] <= products[lane];
                    end else begin
                        // plain wrap, no saturation
                        accumulators[lane] <= accumulators[lane] + products[lane];
                    end
                end
            end
        end
    end

    // bank follows the lanes, only meaningful with result_valid
    always_ff @(posedge clk) begin
        if (enable) begin
            result_bank <= issue_bus.out_bank;
        end
    end

endmodule

// File: verilog/relu_writeback.sv
`timescale 1ns/1ns
`include "gemm_params.svh"

module relu_writeback import gemm_pkg::*; (
    input logic clk,
    input logic reset,
    input logic enable,
    input act_vector_t activations_in,
    input acc_vector_t accumulators,
    input logic result_valid,
    input bank_t result_bank,
    output act_vector_t activations_out
);

    acc_vector_t scaled;
    act_t [`GEMM_MAC_COUNT-1:0] relu_lanes;
    act_vector_t next_vector;

    // relu per lane: negative -> 0, else acc / 128 clamped to 127
    always_comb begin
        for (int lane = 0; lane < `GEMM_MAC_COUNT; lane++) begin
            scaled[lane] = accumulators[lane] >> `GEMM_RELU_SHIFT;
            if (accumulators[lane][`GEMM_ACC_WIDTH-1]) begin
                relu_lanes[lane] = '0;
            end else if (scaled[lane] > `GEMM_RELU_MAX) begin
                relu_lanes[lane] = act_t'(`GEMM_RELU_MAX);
            end else begin
                relu_lanes[lane] = scaled[lane][`GEMM_DATA_WIDTH-1:0];
            end
        end
    end

    // pass-through with the result bank replaced
    always_comb begin
        next_vector = activations_in;
        if (result_valid) begin
            for (int lane = 0; lane < `GEMM_MAC_COUNT; lane++) begin
                next_vector[{result_bank, lane[`GEMM_LANE_BITS-1:0]}] = relu_lanes[lane];
            end
        end
    end

    // restart leaves the vector alone
    always_ff @(posedge clk) begin
        if (reset) begin
            activations_out <= '0;
        end else if (enable) begin
            activations_out <= next_vector;
        end
    end

endmodule

// File: verilog/gemm_processor.sv
`timescale 1ns/1ns
`include "gemm_params.svh"

module gemm_processor import gemm_pkg::*; (
    input logic clk,
    input logic reset,
    input logic enable,
    input logic restart_program,
    // vector coming back around the external loop
    input act_vector_t activations_in,
    // program write port
    input logic program_write,
    input logic [`GEMM_PC_WIDTH-1:0] program_addr,
    input command_t program_data,
    // weight write port, one row per write
    input logic weight_write,
    input logic [`GEMM_ROW_WIDTH-1:0] weight_row,
    input weight_row_t weight_data,
    output act_vector_t activations_out,
    // pc, zero extended
    output logic [`GEMM_PROGRESS_WIDTH-1:0] progress,
    output command_t command
);

    // decode to lanes
    gemm_issue_if issue_bus ();

    // lanes to writeback and back to the hazard check
    acc_vector_t accumulators;
    logic result_valid;
    bank_t result_bank;

    // program, weights, pc, stall and issue
    command_decode decode0 (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .restart_program(restart_program),
        .activations_in(activations_in),
        .program_write(program_write),
        .program_addr(program_addr),
        .program_data(program_data),
        .weight_write(weight_write),
        .weight_row(weight_row),
        .weight_data(weight_data),
        .result_valid(result_valid),
        .result_bank(result_bank),
        .progress(progress),
        .command(command),
        .issue_bus(issue_bus)
    );

    // 32 accumulator lanes
    mac_array mac0 (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .restart_program(restart_program),
        .issue_bus(issue_bus),
        .accumulators(accumulators),
        .result_valid(result_valid),
        .result_bank(result_bank)
    );

    // relu and bank write into the outgoing vector
    relu_writeback writeback0 (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .activations_in(activations_in),
        .accumulators(accumulators),
        .result_valid(result_valid),
        .result_bank(result_bank),
        .activations_out(activations_out)
    );

endmodule

// File: bench/gemm_model.svh
`ifndef GEMM_MODEL_SVH
`define GEMM_MODEL_SVH

// lfsr state, stepped once per bit taken
logic [31:0] lfsr_state = 32'h33ff;

// reference vector, program and weight rows of the current test
act_vector_t expected;
command_t program_q[$];
weight_row_t weight_q[$];

// fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

// one step per bit, newest bit at the bottom
function automatic logic [31:0] take_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        value = {value[30:0], lfsr_state[0]};
    end
    return value;
endfunction

function automatic act_vector_t random_vector();
    act_vector_t vector;
    for (int i = 0; i < 128; i++) begin
        vector[i] = act_t'(take_bits(8));
    end
    return vector;
endfunction

// negative gives 0, else divide by 128 and clamp to 127
function automatic act_t clamped_relu(input int sum);
    int scaled;
    scaled = sum / 128;
    if (sum < 0) begin
        return act_t'(0);
    end
    if (scaled > 127) begin
        return act_t'(127);
    end
    return act_t'(scaled);
endfunction

// one group of 32 commands, activation k times weight row first_row + k
task automatic apply_layer(input int in_bank, input int out_bank, input int first_row);
    int sum;
    act_t [31:0] lanes;
    for (int lane = 0; lane < 32; lane++) begin
        sum = 0;
        for (int k = 0; k < 32; k++) begin
            sum += int'($signed(expected[in_bank * 32 + k])) *
                int'($signed(weight_q[first_row + k][lane]));
        end
        lanes[lane] = clamped_relu(sum);
    end
    for (int lane = 0; lane < 32; lane++) begin
        expected[out_bank * 32 + lane] = lanes[lane];
    end
endtask

// clear only on the first command of the group
task automatic append_group(input bank_t in_bank, input bank_t out_bank);
    command_t cmd;
    for (int k = 0; k < 32; k++) begin
        cmd.clear = (k == 0);
        cmd.in_bank = in_bank;
        // reserved bits set on purpose, design ignores them
        cmd.reserved = 3'b101;
        cmd.out_bank = out_bank;
        program_q.push_back(cmd);
    end
endtask

// trailing clears into bank 3, never read back
task automatic append_tail();
    command_t cmd;
    for (int k = 0; k < 8; k++) begin
        cmd = '{clear: 1'b1, in_bank: 2'd0, reserved: 3'b000, out_bank: 2'd3};
        program_q.push_back(cmd);
    end
endtask

task automatic fill_random_weights(input int count);
    weight_row_t row;
    logic [31:0] bits;
    for (int r = 0; r < count; r++) begin
        for (int lane = 0; lane < 32; lane++) begin
            bits = take_bits(5);
            // small signed weights keep most sums inside the relu range
            row[lane] = {{3{bits[4]}}, bits[4:0]};
        end
        weight_q.push_back(row);
    end
endtask

// lanes 0..3 aimed at the relu limits, rest random
task automatic fill_relu_weights();
    weight_row_t row;
    logic [31:0] bits;
    for (int k = 0; k < 32; k++) begin
        for (int lane = 4; lane < 32; lane++) begin
            bits = take_bits(5);
            row[lane] = {{3{bits[4]}}, bits[4:0]};
        end
        // huge positive sum
        row[0] = 8'sd127;
        // huge negative sum
        row[1] = 8'h80;
        // 127*127 + 1*126 = 16255, one below 128*127
        row[2] = (k == 0) ? 8'sd127 : ((k == 1) ? 8'sd126 : 8'sd0);
        // exactly 128*127
        row[3] = (k < 2) ? 8'sd127 : 8'sd0;
        weight_q.push_back(row);
    end
endtask

// banks 0..2 against the model, bank 3 belongs to the tail
task automatic compare_banks();
    logic [1023:0] got;
    logic [1023:0] want;
    got = activations_out;
    want = expected;
    for (int bank = 0; bank < 3; bank++) begin
        assert (got[bank * 256 +: 256] == want[bank * 256 +: 256])
            else report_mismatch($sformatf("activations_out bank %0d", bank),
                got[bank * 256 +: 256], want[bank * 256 +: 256]);
    end
endtask

`endif

// File: bench/gemm_tb.sv
`timescale 1ns/1ns
`include "gemm_params.svh"

module gemm_tb import gemm_pkg::*; ();

    logic clk = 1'b0;
    logic reset;
    logic enable;
    logic restart_program;
    act_vector_t activations_in;
    act_vector_t preload;
    logic program_write;
    logic [`GEMM_PC_WIDTH-1:0] program_addr;
    command_t program_data;
    logic weight_write;
    logic [`GEMM_ROW_WIDTH-1:0] weight_row;
    weight_row_t weight_data;
    act_vector_t activations_out;
    logic [`GEMM_PROGRESS_WIDTH-1:0] progress;
    command_t command;
    int cycles;

    // 4 ns clock
    always #2 clk = ~clk;

    // output looped back to the input except during restart
    assign activations_in = restart_program ? preload : activations_out;

    gemm_processor dut0 (
        .clk(clk),
        .reset(reset),
        .enable(enable),
        .restart_program(restart_program),
        .activations_in(activations_in),
        .program_write(program_write),
        .program_addr(program_addr),
        .program_data(program_data),
        .weight_write(weight_write),
        .weight_row(weight_row),
        .weight_data(weight_data),
        .activations_out(activations_out),
        .progress(progress),
        .command(command)
    );

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [1023:0] got,
            input logic [1023:0] want);
        $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, want);
        stop_on_error();
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        stop_on_error();
    endtask

    `include "gemm_model.svh"

    // pc pinned at zero during restart
    assert property (@(posedge clk) disable iff (reset)
        restart_program |=> progress == 0)
        else report_mismatch("progress", progress, 0);

    // restart keeps the pass-through running
    assert property (@(posedge clk) disable iff (reset)
        restart_program && enable |=> activations_out == $past(activations_in))
        else report_failure("activations_out did not follow activations_in in restart");

    // everything holds while enable is low
    assert property (@(posedge clk) disable iff (reset)
        !enable && !restart_program |=>
            progress == $past(progress) && activations_out == $past(activations_out))
        else report_failure("progress or activations_out moved while enable was low");

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // flush with enable low and then write program and weights under restart
    task automatic load_program(input act_vector_t vector);
        restart_program = 1'b1;
        enable = 1'b0;
        preload = vector;
        next_cycle();
        enable = 1'b1;
        for (int i = 0; i < program_q.size(); i++) begin
            program_write = 1'b1;
            program_addr = 9'(i);
            program_data = program_q[i];
            next_cycle();
        end
        program_write = 1'b0;
        for (int i = 0; i < weight_q.size(); i++) begin
            weight_write = 1'b1;
            weight_row = 9'(i);
            weight_data = weight_q[i];
            next_cycle();
        end
        weight_write = 1'b0;
        next_cycle();
        assert (command == program_q[0])
            else report_mismatch("command", command, program_q[0]);
        assert (activations_out == vector)
            else report_mismatch("activations_out", activations_out, vector);
        restart_program = 1'b0;
    endtask

    // run until the last group has drained and freeze once at freeze_at
    task automatic run_program(input int end_pc, input int freeze_at, output int used);
        bit frozen;
        frozen = 1'b0;
        used = 0;
        while (progress < end_pc + 3) begin
            next_cycle();
            used++;
            if (used > 300) begin
                report_failure("timed out waiting for progress to pass the program");
            end
            if (!frozen && progress == freeze_at) begin
                enable = 1'b0;
                for (int i = 0; i < 6; i++) begin
                    next_cycle();
                end
                enable = 1'b1;
                frozen = 1'b1;
            end
        end
        // hold the result before the tail runs far
        enable = 1'b0;
        next_cycle();
    endtask

    // empty program and weights for a new test
    task automatic clear_test();
        program_q.delete();
        weight_q.delete();
    endtask

    initial begin
        reset = 1'b1;
        enable = 1'b0;
        restart_program = 1'b0;
        preload = '0;
        program_write = 1'b0;
        program_addr = '0;
        program_data = '0;
        weight_write = 1'b0;
        weight_row = '0;
        weight_data = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();

        // reset values
        assert (progress == 0) else report_mismatch("progress", progress, 0);
        assert (activations_out == '0)
            else report_mismatch("activations_out", activations_out, 0);

        // two groups from bank 0 into banks 2 and 1
        clear_test();
        append_group(2'd0, 2'd2);
        append_group(2'd0, 2'd1);
        append_tail();
        fill_random_weights(64);
        expected = random_vector();
        load_program(expected);
        apply_layer(0, 2, 0);
        apply_layer(0, 1, 32);
        run_program(64, -1, cycles);
        compare_banks();

        // relu limits on lanes 0..3 of bank 2
        clear_test();
        append_group(2'd0, 2'd2);
        append_tail();
        fill_relu_weights();
        expected = random_vector();
        for (int k = 0; k < 32; k++) begin
            expected[k] = (k == 1) ? 8'sd1 : 8'sd127;
        end
        load_program(expected);
        apply_layer(0, 2, 0);
        run_program(32, -1, cycles);
        compare_banks();
        assert (activations_out[64] == 8'sd127)
            else report_mismatch("activations_out lane 0", activations_out[64], 127);
        assert (activations_out[65] == 8'sd0)
            else report_mismatch("activations_out lane 1", activations_out[65], 0);
        assert (activations_out[66] == 8'sd126)
            else report_mismatch("activations_out lane 2", activations_out[66], 126);
        assert (activations_out[67] == 8'sd127)
            else report_mismatch("activations_out lane 3", activations_out[67], 127);

        // second layer reads bank 2 right after it is written
        clear_test();
        append_group(2'd0, 2'd2);
        append_group(2'd2, 2'd1);
        append_tail();
        fill_random_weights(64);
        expected = random_vector();
        load_program(expected);
        apply_layer(0, 2, 0);
        apply_layer(2, 1, 32);
        run_program(64, -1, cycles);
        // no stall would finish in exactly 67 cycles
        assert (cycles > 67) else report_failure("chained layers ran without a stall");
        compare_banks();

        // three chained layers with enable dropped at the first stall
        clear_test();
        append_group(2'd0, 2'd2);
        append_group(2'd2, 2'd1);
        append_group(2'd1, 2'd2);
        append_tail();
        fill_random_weights(96);
        expected = random_vector();
        load_program(expected);
        apply_layer(0, 2, 0);
        apply_layer(2, 1, 32);
        apply_layer(1, 2, 64);
        run_program(96, 32, cycles);
        compare_banks();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: src.f
+incdir+verilog
+incdir+bench
verilog/gemm_pkg.sv
verilog/gemm_issue_if.sv
verilog/command_decode.sv
verilog/mac_array.sv
verilog/relu_writeback.sv
verilog/gemm_processor.sv
bench/gemm_tb.sv

// File: Makefile
# Verilator build and run of the gemm_processor testbench
# every variable can be overridden on the command line, e.g. make run TOP=gemm_tb

VERILATOR ?= verilator
TOP ?= gemm_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --assert -Wno-fatal

# sources come from the file list, headers from the include directories
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard verilog/*.svh bench/*.svh)
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

# rebuilt only when a source, a header or the file list changes
$(BINARY): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the result of the run
run: $(BINARY)
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)
